// ==== source/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Integer data path width
`define XLEN        64

// Architectural register index
`define REG_IDX_W   5

// Data RAM depth in XLEN words
`define DMEM_WORDS  256

// addi x0, x0, 0
`define INST_NOP    32'h0000_0013

`endif

// ==== source/core_pkg.sv ====
`include "lsu_defs.svh"

package core_pkg;

    typedef enum logic [3:0] {
        MEM_NONE,
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU,
        SB,
        SH,
        SW,
        SD
    } mem_op_e;

    // Access size, log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_D
    } mem_size_e;

    typedef struct packed {
        mem_op_e                op;
        logic [`REG_IDX_W-1:0]  rd_index;
        logic                   rd_en;
        logic [`XLEN-1:0]       alu_result;
        logic [`XLEN-1:0]       store_data;
        logic                   inst_trap;
        logic                   intp_en;
        logic [`XLEN-1:0]       csr_nxt_pc;
        logic [`XLEN-1:0]       inst_addr;
    } ex2mem_t;

    typedef struct packed {
        logic [`REG_IDX_W-1:0]  rd_index;
        logic                   rd_en;
        logic [`XLEN-1:0]       rd_data;
        logic                   inst_trap;
        logic                   intp_en;
        logic [`XLEN-1:0]       csr_nxt_pc;
    } mem2wb_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
    } redirect_t;

endpackage

// ==== source/data_ram.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module data_ram (
    input  logic                            clk,
    input  logic [$clog2(`DMEM_WORDS)-1:0]  addr_i,
    input  logic [`XLEN/8-1:0]              wmask_i,
    input  logic [`XLEN-1:0]                wdata_i,
    output logic [`XLEN-1:0]                rdata_o
);

    localparam int BYTES = `XLEN / 8;

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES; b++) begin
            if (wmask_i[b]) begin
                mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    // Read returns contents from before the current edge
    assign rdata_o = mem[addr_i];

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module mem_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            valid_i,
    input  core_pkg::ex2mem_t               ex_i,
    output logic [$clog2(`DMEM_WORDS)-1:0]  ram_addr_o,
    output logic [`XLEN/8-1:0]              ram_wmask_o,
    output logic [`XLEN-1:0]                ram_wdata_o,
    input  logic [`XLEN-1:0]                ram_rdata_i,
    output logic                            valid_o,
    output logic                            flush_o,
    output core_pkg::mem2wb_t               wb_o
);

    import core_pkg::*;

    localparam int ADDR_W = $clog2(`DMEM_WORDS);
    localparam int LANE_W = $clog2(`XLEN / 8);

    mem_size_e              size;
    logic                   is_load;
    logic                   is_store;
    logic                   is_signed;
    logic [LANE_W-1:0]      lane;
    logic [LANE_W-1:0]      align_mask;
    logic [`XLEN/8-1:0]     base_mask;
    logic [`XLEN-1:0]       shifted;
    logic [`XLEN-1:0]       load_data;

    always_comb begin
        is_load   = ex_i.op inside {LB, LH, LW, LD, LBU, LHU, LWU};
        is_store  = ex_i.op inside {SB, SH, SW, SD};
        is_signed = ex_i.op inside {LB, LH, LW};
        case (ex_i.op)
            LB, LBU, SB: size = SIZE_B;
            LH, LHU, SH: size = SIZE_H;
            LW, LWU, SW: size = SIZE_W;
            default:     size = SIZE_D;
        endcase
    end

    always_comb begin
        case (size)
            SIZE_B: begin
                base_mask  = 'h01;
                align_mask = 'd0;
            end
            SIZE_H: begin
                base_mask  = 'h03;
                align_mask = 'd1;
            end
            SIZE_W: begin
                base_mask  = 'h0f;
                align_mask = 'd3;
            end
            default: begin
                base_mask  = 'hff;
                align_mask = 'd7;
            end
        endcase
    end

    assign lane       = ex_i.alu_result[LANE_W-1:0];
    assign ram_addr_o = ex_i.alu_result[LANE_W +: ADDR_W];

    // Store data moved into its byte lanes
    assign ram_wdata_o = ex_i.store_data << {lane, 3'b000};
    assign ram_wmask_o = (valid_i && is_store && !flush_o) ? (base_mask << lane) : '0;

    // Load data brought down to bit 0, then extended
    always_comb begin
        shifted = ram_rdata_i >> {lane, 3'b000};
        case (size)
            SIZE_B:  load_data = {{(`XLEN-8){is_signed & shifted[7]}}, shifted[7:0]};
            SIZE_H:  load_data = {{(`XLEN-16){is_signed & shifted[15]}}, shifted[15:0]};
            SIZE_W:  load_data = {{(`XLEN-32){is_signed & shifted[31]}}, shifted[31:0]};
            default: load_data = shifted;
        endcase
    end

    assign valid_o = valid_i;
    assign flush_o = valid_i & ex_i.intp_en;

    always_comb begin
        wb_o.rd_index   = ex_i.rd_index;
        wb_o.rd_en      = ex_i.rd_en;
        wb_o.rd_data    = is_load ? load_data : ex_i.alu_result;
        wb_o.inst_trap  = ex_i.inst_trap;
        wb_o.intp_en    = ex_i.intp_en;
        wb_o.csr_nxt_pc = ex_i.csr_nxt_pc;
    end

    // Execute stage only issues naturally aligned accesses
    a_aligned: assert property (@(posedge clk) disable iff (rst)
        valid_i && (is_load || is_store) |-> (lane & align_mask) == '0)
        else $error("misaligned access from pc %h", ex_i.inst_addr);

endmodule

// ==== source/mem2wb.sv ====
`timescale 1ns/1ps

module mem2wb (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_i,
    input  logic                flush_i,
    input  core_pkg::mem2wb_t   wb_i,
    output logic                valid_o,
    output core_pkg::mem2wb_t   wb_o
);

    import core_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Holds its contents while no new instruction arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_o <= '0;
        end else if (flush_i) begin
            wb_o.rd_index   <= '0;
            wb_o.rd_en      <= 1'b0;
            wb_o.rd_data    <= '0;
            wb_o.inst_trap  <= 1'b0;
            // interrupt entry still needs its target pc
            wb_o.intp_en    <= wb_i.intp_en;
            wb_o.csr_nxt_pc <= wb_i.csr_nxt_pc;
        end else if (valid_i) begin
            wb_o <= wb_i;
        end
    end

    // Flushed entry still redirects but never writes a register
    a_flush_no_write: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> valid_o && wb_o.intp_en && !wb_o.rd_en)
        else $error("flushed entry lost its interrupt or kept rd_en");

endmodule

// ==== source/wb_regfile.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module wb_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_i,
    input  core_pkg::mem2wb_t       wb_i,
    input  logic [`REG_IDX_W-1:0]   raddr_i,
    output logic [`XLEN-1:0]        rdata_o,
    output core_pkg::redirect_t     redirect_o
);

    import core_pkg::*;

    localparam int NREGS = 1 << `REG_IDX_W;

    logic [`XLEN-1:0]   regs [NREGS];
    logic               wr_en;

    // Trapped instructions and x0 never update state
    assign wr_en = valid_i && wb_i.rd_en && !wb_i.inst_trap && (wb_i.rd_index != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd_index] <= wb_i.rd_data;
        end
    end

    assign rdata_o = regs[raddr_i];

    // One cycle per captured entry, since valid drops on hold
    always_comb begin
        redirect_o.valid = valid_i && (wb_i.inst_trap || wb_i.intp_en);
        redirect_o.pc    = wb_i.csr_nxt_pc;
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        raddr_i == '0 |-> rdata_o == '0)
        else $error("x0 reads %h", rdata_o);

endmodule

// ==== source/mem_wb_top.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module mem_wb_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ex_valid_i,
    input  core_pkg::ex2mem_t       ex_i,
    input  logic [`REG_IDX_W-1:0]   rd_raddr_i,
    output logic [`XLEN-1:0]        rd_rdata_o,
    output core_pkg::redirect_t     redirect_o
);

    import core_pkg::*;

    logic [$clog2(`DMEM_WORDS)-1:0] ram_addr;
    logic [`XLEN/8-1:0]             ram_wmask;
    logic [`XLEN-1:0]               ram_wdata;
    logic [`XLEN-1:0]               ram_rdata;

    logic       mem_valid;
    logic       mem_flush;
    mem2wb_t    mem_wb;
    logic       wb_valid;
    mem2wb_t    wb_q;

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (ex_valid_i),
        .ex_i        (ex_i),
        .ram_addr_o  (ram_addr),
        .ram_wmask_o (ram_wmask),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .valid_o     (mem_valid),
        .flush_o     (mem_flush),
        .wb_o        (mem_wb)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .wmask_i (ram_wmask),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    mem2wb u_mem2wb (
        .clk     (clk),
        .rst     (rst),
        .valid_i (mem_valid),
        .flush_i (mem_flush),
        .wb_i    (mem_wb),
        .valid_o (wb_valid),
        .wb_o    (wb_q)
    );

    wb_regfile u_wb_regfile (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (wb_valid),
        .wb_i       (wb_q),
        .raddr_i    (rd_raddr_i),
        .rdata_o    (rd_rdata_o),
        .redirect_o (redirect_o)
    );

endmodule

// ==== test/tb_mem_wb_model.svh ====
`ifndef TB_MEM_WB_MODEL_SVH
`define TB_MEM_WB_MODEL_SVH

logic [31:0]        lfsr_state = 32'hd461_7077;
logic [7:0]         model_mem [`DMEM_WORDS * 8];
logic [`XLEN-1:0]   model_regs [1 << `REG_IDX_W];

// Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v = {v[62:0], fb};
    end
    return v;
endfunction

function automatic void model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
endfunction

function automatic int op_bytes(input mem_op_e op);
    case (op)
        LB, LBU, SB: return 1;
        LH, LHU, SH: return 2;
        LW, LWU, SW: return 4;
        default:     return 8;
    endcase
endfunction

function automatic logic is_load_op(input mem_op_e op);
    return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
endfunction

function automatic logic is_store_op(input mem_op_e op);
    return op inside {SB, SH, SW, SD};
endfunction

// Little-endian bytes from the model RAM, then sign or zero extension
function automatic logic [`XLEN-1:0] load_extend(input mem_op_e op,
                                                 input logic [`XLEN-1:0] addr);
    logic [`XLEN-1:0] v;
    int               n;
    int               base;
    n = op_bytes(op);
    base = int'(addr % (`DMEM_WORDS * 8));
    v = '0;
    for (int i = n - 1; i >= 0; i--) begin
        v = {v[`XLEN-9:0], model_mem[base + i]};
    end
    if ((op inside {LB, LH, LW}) && v[8*n-1]) begin
        for (int b = 8 * n; b < `XLEN; b++) begin
            v[b] = 1'b1;
        end
    end
    return v;
endfunction

function automatic void store_bytes(input mem_op_e op, input logic [`XLEN-1:0] addr,
                                    input logic [`XLEN-1:0] data);
    int base;
    base = int'(addr % (`DMEM_WORDS * 8));
    for (int i = 0; i < op_bytes(op); i++) begin
        model_mem[base + i] = data[8*i +: 8];
    end
endfunction

// Register value expected once the instruction has retired
function automatic logic [`XLEN-1:0] expected_reg(input ex2mem_t ex);
    if (ex.rd_en && !ex.inst_trap && !ex.intp_en && ex.rd_index != '0) begin
        return is_load_op(ex.op) ? load_extend(ex.op, ex.alu_result) : ex.alu_result;
    end
    return model_regs[ex.rd_index];
endfunction

function automatic redirect_t expected_redirect(input ex2mem_t ex);
    redirect_t r;
    r.valid = ex.inst_trap || ex.intp_en;
    r.pc    = ex.csr_nxt_pc;
    return r;
endfunction

function automatic void apply_model(input ex2mem_t ex);
    model_regs[ex.rd_index] = expected_reg(ex);
    // Interrupted stores never reach memory
    if (is_store_op(ex.op) && !ex.intp_en) begin
        store_bytes(ex.op, ex.alu_result, ex.store_data);
    end
endfunction

`endif

// ==== test/tb_mem_wb.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_mem_wb;

    import core_pkg::*;

    localparam int FILL_WORDS  = 16;
    localparam int N_ALU       = 40;
    localparam int N_LDST      = 60;
    localparam int N_INTP      = 20;
    localparam int N_TRAP      = 20;
    localparam int N_BUB       = 40;
    localparam int TOTAL_INSTR = FILL_WORDS + N_ALU + N_LDST + 2 * N_INTP + N_TRAP + N_BUB;
    localparam int CYCLE_LIMIT = 3 * TOTAL_INSTR + 200;

    logic                   clk;
    logic                   rst;
    logic                   ex_valid;
    ex2mem_t                ex_in;
    logic [`REG_IDX_W-1:0]  rd_raddr;
    logic [`XLEN-1:0]       rd_rdata;
    redirect_t              redirect;

    int issued = 0;
    int checked = 0;
    int checks = 0;
    int errors = 0;
    int cycles = 0;

    // Expected results, one stage per DUT pipeline step
    logic                   s1_valid;
    logic [`REG_IDX_W-1:0]  s1_idx;
    logic [`XLEN-1:0]       s1_val;
    redirect_t              s1_redir;
    logic                   s2_valid;
    logic [`REG_IDX_W-1:0]  s2_idx;
    logic [`XLEN-1:0]       s2_val;

    `include "tb_mem_wb_model.svh"

    mem_wb_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .ex_valid_i (ex_valid),
        .ex_i       (ex_in),
        .rd_raddr_i (rd_raddr),
        .rd_rdata_o (rd_rdata),
        .redirect_o (redirect)
    );

    always #5 clk = ~clk;

    task automatic check_reg(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // pc only matters while a redirect is expected
    task automatic check_redirect(input redirect_t got, input redirect_t exp);
        checks++;
        if (got.valid !== exp.valid || (exp.valid && got.pc !== exp.pc)) begin
            errors++;
            $display("FAIL t=%0t redirect_o got %0b/%h expected %0b/%h", $time,
                     got.valid, got.pc, exp.valid, exp.pc);
        end
    endtask

    function automatic mem_op_e rand_op(input int nbits, input int span);
        return mem_op_e'(4'(rand_bits(nbits) % span));
    endfunction

    // Random fields, memory accesses aligned inside the first FILL_WORDS words
    function automatic ex2mem_t make_instr(input mem_op_e op);
        ex2mem_t          e;
        logic [63:0]      word;
        logic [63:0]      off;
        e = '0;
        e.op = op;
        e.rd_index = `REG_IDX_W'(rand_bits(`REG_IDX_W));
        e.rd_en = !is_store_op(op);
        e.store_data = rand_bits(64);
        e.csr_nxt_pc = rand_bits(64) & ~64'h3;
        e.inst_addr = rand_bits(64) & ~64'h3;
        if (op == MEM_NONE) begin
            e.alu_result = rand_bits(64);
        end else begin
            word = rand_bits(4);
            off = rand_bits(3);
            e.alu_result = (word << 3) | (off & ~64'(op_bytes(op) - 1));
        end
        return e;
    endfunction

    task automatic issue(input ex2mem_t instr);
        @(posedge clk);
        ex_valid <= 1'b1;
        ex_in <= instr;
        issued++;
    endtask

    // Idle cycles with junk on the bus
    task automatic bubble(input int n);
        ex2mem_t junk;
        for (int i = 0; i < n; i++) begin
            junk = make_instr(rand_op(4, 12));
            junk.intp_en = 1'(rand_bits(1));
            junk.inst_trap = 1'(rand_bits(1));
            @(posedge clk);
            ex_valid <= 1'b0;
            ex_in <= junk;
        end
    endtask

    task automatic drain();
        @(posedge clk);
        ex_valid <= 1'b0;
        wait (checked == issued);
        @(negedge clk);
    endtask

    task automatic report(input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_mark);
        end
    endtask

    // Redirect checked one cycle after capture, register one cycle later
    always @(negedge clk) begin
        if (!rst) begin
            check_redirect(redirect, s1_redir);
            if (s2_valid) begin
                check_reg($sformatf("rd_rdata_o[x%0d]", s2_idx), rd_rdata, s2_val);
                checked++;
            end
        end
        s2_valid = s1_valid;
        s2_idx = s1_idx;
        s2_val = s1_val;
        s1_valid = ex_valid && !rst;
        s1_redir = '0;
        if (s1_valid) begin
            s1_idx = ex_in.rd_index;
            s1_val = expected_reg(ex_in);
            s1_redir = expected_redirect(ex_in);
            apply_model(ex_in);
        end
    end

    always @(posedge clk) begin
        if (s2_valid) begin
            rd_raddr <= s2_idx;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, pipeline never drained", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int      err_mark;
        ex2mem_t instr;
        ex2mem_t follow;
        clk = 1'b0;
        rst = 1'b1;
        ex_valid = 1'b0;
        ex_in = '0;
        rd_raddr = '0;
        s1_valid = 1'b0;
        s2_valid = 1'b0;
        s1_redir = '0;
        model_reset();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        err_mark = errors;
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            rd_raddr <= `REG_IDX_W'(i);
            @(negedge clk);
            check_reg($sformatf("rd_rdata_o[x%0d]", i), rd_rdata, '0);
        end
        report("reset_state", err_mark);

        err_mark = errors;
        for (int i = 0; i < N_ALU; i++) begin
            instr = make_instr(MEM_NONE);
            if (i % 8 == 3) begin
                instr.rd_index = '0;
            end
            issue(instr);
        end
        drain();
        report("alu_writeback", err_mark);

        // Known contents first, then store and load to the same word back to back
        err_mark = errors;
        for (int w = 0; w < FILL_WORDS; w++) begin
            instr = make_instr(SD);
            instr.alu_result = 64'(w * 8);
            issue(instr);
        end
        for (int i = 0; i < N_LDST / 2; i++) begin
            instr = make_instr(mem_op_e'(int'(SB) + i % 4));
            follow = make_instr(mem_op_e'(int'(LB) + i % 7));
            follow.alu_result[`XLEN-1:3] = instr.alu_result[`XLEN-1:3];
            issue(instr);
            issue(follow);
        end
        drain();
        report("store_load", err_mark);

        err_mark = errors;
        for (int i = 0; i < N_INTP; i++) begin
            instr = make_instr(rand_op(4, 12));
            instr.rd_en = !is_store_op(instr.op);
            instr.intp_en = 1'b1;
            follow = make_instr(LD);
            follow.alu_result[`XLEN-1:3] = instr.alu_result[`XLEN-1:3];
            issue(instr);
            issue(follow);
        end
        drain();
        report("interrupt_flush", err_mark);

        err_mark = errors;
        for (int i = 0; i < N_TRAP; i++) begin
            instr = make_instr(rand_op(3, 8));
            instr.inst_trap = 1'b1;
            issue(instr);
        end
        drain();
        report("trap", err_mark);

        err_mark = errors;
        for (int i = 0; i < N_BUB; i++) begin
            issue(make_instr(rand_op(4, 12)));
            bubble(int'(rand_bits(2)));
        end
        drain();
        report("bubbles", err_mark);

        $display("Summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+source
+incdir+test
source/core_pkg.sv
source/data_ram.sv
source/mem_stage.sv
source/mem2wb.sv
source/wb_regfile.sv
source/mem_wb_top.sv
test/tb_mem_wb.sv
